// File: hdl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers
`define RV_REG_COUNT 32

// Fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Sequential fetch increment
`define RV_PC_STEP 32'd4

`endif

// File: hdl/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// Branch and memory offsets, sign-extended in execute
	localparam int OFFSET_W = 13;
	typedef logic [OFFSET_W-1:0] offset_t;

	typedef enum logic [4:0] {
		EXE_ADD   = 5'b00000,
		EXE_SUB   = 5'b00001,
		EXE_SLT   = 5'b00010,
		EXE_SLTU  = 5'b00011,
		EXE_AND   = 5'b00100,
		EXE_OR    = 5'b00101,
		EXE_XOR   = 5'b00110,
		EXE_SLL   = 5'b00111,
		EXE_SRL   = 5'b01000,
		EXE_SRA   = 5'b01001,
		EXE_LUI   = 5'b01010,
		EXE_JUMP  = 5'b01011,
		EXE_BEQ   = 5'b01100,
		EXE_BNE   = 5'b01101,
		EXE_BLT   = 5'b01110,
		EXE_BLTU  = 5'b01111,
		EXE_LOAD  = 5'b10000,
		EXE_STORE = 5'b10001,
		EXE_NOP   = 5'b10011
	} exe_op_t;

	typedef enum logic [2:0] {
		MEM_FORWARD = 3'b000,
		MEM_JUMP    = 3'b001,
		MEM_LOAD    = 3'b010,
		MEM_STORE   = 3'b011,
		MEM_NOP     = 3'b101
	} mem_op_t;

	typedef enum logic [1:0] {
		WB_WRITE = 2'b00,
		WB_JUMP  = 2'b01,
		WB_NOP   = 2'b11
	} wb_op_t;

	typedef struct packed {
		exe_op_t  op;
		reg_idx_t rd;
		word_t    pc;
		word_t    op1;
		word_t    op2;
		reg_idx_t rs1;
		reg_idx_t rs2;
		offset_t  offset;
		// Swapped BGE/BGEU, taken when op1 <= op2
		logic     or_equal;
	} id_exe_t;

	typedef struct packed {
		mem_op_t  op;
		reg_idx_t rd;
		word_t    target;
		word_t    result;
	} exe_mem_t;

	typedef struct packed {
		wb_op_t   op;
		reg_idx_t rd;
		word_t    result;
		word_t    target;
	} mem_wb_t;

	typedef struct packed {
		logic     en;
		reg_idx_t rd;
		word_t    data;
	} reg_write_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

endpackage

// File: hdl/rv_fetch.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_fetch (
	input  logic              clk,
	input  logic              reset,
	input  rv_pkg::redirect_t redirect,
	output rv_pkg::word_t     imem_addr,
	input  rv_pkg::word_t     imem_data,
	output logic              id_valid,
	output rv_pkg::word_t     id_inst,
	output rv_pkg::word_t     id_pc
);
	import rv_pkg::*;

	word_t pc;

	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RV_RESET_PC;
		end else if (redirect.valid) begin
			pc <= redirect.target;
		end else begin
			pc <= pc + `RV_PC_STEP;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		id_inst <= imem_data;
		id_pc <= pc;
		// The word fetched during a redirect is on the wrong path
		if (reset || redirect.valid) begin
			id_valid <= 1'b0;
		end else begin
			id_valid <= 1'b1;
		end
	end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_regfile (
	input  logic               clk,
	input  logic               reset,
	input  rv_pkg::reg_idx_t   rs1_idx,
	input  rv_pkg::reg_idx_t   rs2_idx,
	output rv_pkg::word_t      rs1_val,
	output rv_pkg::word_t      rs2_val,
	input  rv_pkg::reg_write_t wb_write
);
	import rv_pkg::*;

	word_t regs [`RV_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_write.en) begin
			regs[wb_write.rd] <= wb_write.data;
		end
	end

	// x0 always reads zero, even after a write to it
	// Same-cycle write-back is bypassed to the read ports
	assign rs1_val = (rs1_idx == '0) ? '0 :
		(wb_write.en && wb_write.rd == rs1_idx) ? wb_write.data :
		regs[rs1_idx];

	assign rs2_val = (rs2_idx == '0) ? '0 :
		(wb_write.en && wb_write.rd == rs2_idx) ? wb_write.data :
		regs[rs2_idx];

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_decode (
	input  logic              clk,
	input  logic              reset,
	input  logic              id_valid,
	input  rv_pkg::word_t     id_inst,
	input  rv_pkg::word_t     id_pc,
	input  rv_pkg::redirect_t redirect,
	output rv_pkg::reg_idx_t  rs1_idx,
	output rv_pkg::reg_idx_t  rs2_idx,
	input  rv_pkg::word_t     rs1_val,
	input  rv_pkg::word_t     rs2_val,
	output rv_pkg::id_exe_t   id_exe
);
	import rv_pkg::*;

	// Major opcodes, instruction bits 6:2
	localparam logic [4:0] OPC_OP_IMM = 5'b00100;
	localparam logic [4:0] OPC_LUI    = 5'b01101;
	localparam logic [4:0] OPC_AUIPC  = 5'b00101;
	localparam logic [4:0] OPC_OP     = 5'b01100;
	localparam logic [4:0] OPC_JAL    = 5'b11011;
	localparam logic [4:0] OPC_JALR   = 5'b11001;
	localparam logic [4:0] OPC_BRANCH = 5'b11000;
	localparam logic [4:0] OPC_LOAD   = 5'b00000;
	localparam logic [4:0] OPC_STORE  = 5'b01000;

	logic [4:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	exe_op_t    alu_op_i;
	exe_op_t    alu_op_r;
	id_exe_t    id_exe_next;

	function automatic exe_op_t alu_op_of(
		input logic [2:0] f3,
		input logic [6:0] f7,
		input logic       reg_form
	);
		logic f7_zero;
		logic f7_alt;
		logic plain;
		exe_op_t op;
		f7_zero = (f7 == 7'b0000000);
		f7_alt = (f7 == 7'b0100000);
		// funct7 is part of the immediate except for shifts
		plain = !reg_form || f7_zero;
		case (f3)
			3'b000: op = plain ? EXE_ADD : (f7_alt ? EXE_SUB : EXE_NOP);
			3'b001: op = f7_zero ? EXE_SLL : EXE_NOP;
			3'b010: op = plain ? EXE_SLT : EXE_NOP;
			3'b011: op = plain ? EXE_SLTU : EXE_NOP;
			3'b100: op = plain ? EXE_XOR : EXE_NOP;
			3'b101: op = f7_zero ? EXE_SRL : (f7_alt ? EXE_SRA : EXE_NOP);
			3'b110: op = plain ? EXE_OR : EXE_NOP;
			default: op = plain ? EXE_AND : EXE_NOP;
		endcase
		return op;
	endfunction

	assign opcode = id_inst[6:2];
	assign funct3 = id_inst[14:12];
	assign funct7 = id_inst[31:25];
	assign rd = id_inst[11:7];
	assign rs1_idx = id_inst[19:15];
	assign rs2_idx = id_inst[24:20];

	assign imm_i = {{(`RV_XLEN-12){id_inst[31]}}, id_inst[31:20]};
	assign imm_s = {{(`RV_XLEN-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
	assign imm_b = {{(`RV_XLEN-13){id_inst[31]}}, id_inst[31], id_inst[7],
		id_inst[30:25], id_inst[11:8], 1'b0};
	assign imm_u = {id_inst[31:12], 12'b0};
	assign imm_j = {{(`RV_XLEN-21){id_inst[31]}}, id_inst[31], id_inst[19:12],
		id_inst[20], id_inst[30:21], 1'b0};

	assign alu_op_i = alu_op_of(funct3, funct7, 1'b0);
	assign alu_op_r = alu_op_of(funct3, funct7, 1'b1);

	always_comb begin
		id_exe_next = '0;
		id_exe_next.op = EXE_NOP;
		id_exe_next.rd = rd;
		id_exe_next.pc = id_pc;
		id_exe_next.op1 = rs1_val;
		id_exe_next.op2 = rs2_val;
		id_exe_next.rs1 = rs1_idx;
		id_exe_next.rs2 = rs2_idx;
		if (id_valid && id_inst[1:0] == 2'b11) begin
			case (opcode)
				OPC_OP_IMM: begin
					id_exe_next.op2 = imm_i;
					id_exe_next.rs2 = '0;
					// addi x0, x0, 0 is the canonical NOP
					if (!(alu_op_i == EXE_ADD && rd == '0 && rs1_idx == '0 && imm_i == '0)) begin
						id_exe_next.op = alu_op_i;
					end
				end
				OPC_OP: begin
					id_exe_next.op = alu_op_r;
				end
				OPC_LUI: begin
					id_exe_next.op = EXE_LUI;
					id_exe_next.op1 = imm_u;
					id_exe_next.rs1 = '0;
					id_exe_next.rs2 = '0;
				end
				OPC_AUIPC: begin
					id_exe_next.op = EXE_ADD;
					id_exe_next.op1 = imm_u;
					id_exe_next.op2 = id_pc;
					id_exe_next.rs1 = '0;
					id_exe_next.rs2 = '0;
				end
				OPC_JAL: begin
					id_exe_next.op = EXE_JUMP;
					id_exe_next.op1 = id_pc;
					id_exe_next.op2 = imm_j;
					id_exe_next.rs1 = '0;
					id_exe_next.rs2 = '0;
				end
				OPC_JALR: begin
					if (funct3 == 3'b000) begin
						id_exe_next.op = EXE_JUMP;
					end
					id_exe_next.op2 = imm_i;
					id_exe_next.rs2 = '0;
				end
				OPC_BRANCH: begin
					// Branches retire through the jump path, link goes to x0
					id_exe_next.rd = '0;
					id_exe_next.offset = imm_b[OFFSET_W-1:0];
					case (funct3)
						3'b000: id_exe_next.op = EXE_BEQ;
						3'b001: id_exe_next.op = EXE_BNE;
						3'b100, 3'b101, 3'b110, 3'b111: begin
							id_exe_next.op = funct3[1] ? EXE_BLTU : EXE_BLT;
							// BGE and BGEU compare rs2 <= rs1
							if (funct3[0]) begin
								id_exe_next.op1 = rs2_val;
								id_exe_next.op2 = rs1_val;
								id_exe_next.rs1 = rs2_idx;
								id_exe_next.rs2 = rs1_idx;
								id_exe_next.or_equal = 1'b1;
							end
						end
						default: id_exe_next.op = EXE_NOP;
					endcase
				end
				OPC_LOAD: begin
					if (funct3 == 3'b010) begin
						id_exe_next.op = EXE_LOAD;
					end
					id_exe_next.rs2 = '0;
					id_exe_next.offset = imm_i[OFFSET_W-1:0];
				end
				OPC_STORE: begin
					if (funct3 == 3'b010) begin
						id_exe_next.op = EXE_STORE;
					end
					id_exe_next.rd = '0;
					id_exe_next.offset = imm_s[OFFSET_W-1:0];
				end
				default: id_exe_next.op = EXE_NOP;
			endcase
		end
	end

	// ID/EX register
	always_ff @(posedge clk) begin
		id_exe <= id_exe_next;
		if (reset || redirect.valid) begin
			id_exe.op <= EXE_NOP;
		end
	end

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_execute (
	input  logic               clk,
	input  logic               reset,
	input  rv_pkg::id_exe_t    id_exe,
	input  rv_pkg::redirect_t  redirect,
	input  rv_pkg::reg_write_t mem_fwd,
	input  rv_pkg::reg_write_t wb_write,
	output rv_pkg::exe_mem_t   exe_mem
);
	import rv_pkg::*;

	localparam int SHAMT_W = $clog2(`RV_XLEN);

	word_t    op1;
	word_t    op2;
	word_t    offset_ext;
	word_t    sum;
	word_t    link;
	word_t    alu_res;
	logic     lt;
	logic     ltu;
	logic     eq;
	logic     taken;
	exe_mem_t exe_mem_next;

	// MEM is younger than WB, so its value wins
	function automatic word_t forward(
		input reg_idx_t   idx,
		input word_t      value,
		input reg_write_t mem_w,
		input reg_write_t wb_w
	);
		word_t res;
		res = value;
		if (idx != '0) begin
			if (mem_w.en && mem_w.rd == idx) begin
				res = mem_w.data;
			end else if (wb_w.en && wb_w.rd == idx) begin
				res = wb_w.data;
			end
		end
		return res;
	endfunction

	assign op1 = forward(id_exe.rs1, id_exe.op1, mem_fwd, wb_write);
	assign op2 = forward(id_exe.rs2, id_exe.op2, mem_fwd, wb_write);

	assign offset_ext = {{(`RV_XLEN-OFFSET_W){id_exe.offset[OFFSET_W-1]}}, id_exe.offset};
	assign sum = op1 + op2;
	assign link = id_exe.pc + `RV_PC_STEP;

	assign lt = $signed(op1) < $signed(op2);
	assign ltu = op1 < op2;
	assign eq = op1 == op2;

	always_comb begin
		case (id_exe.op)
			EXE_SUB:  alu_res = op1 - op2;
			EXE_SLT:  alu_res = word_t'(lt);
			EXE_SLTU: alu_res = word_t'(ltu);
			EXE_AND:  alu_res = op1 & op2;
			EXE_OR:   alu_res = op1 | op2;
			EXE_XOR:  alu_res = op1 ^ op2;
			EXE_SLL:  alu_res = op1 << op2[SHAMT_W-1:0];
			EXE_SRL:  alu_res = op1 >> op2[SHAMT_W-1:0];
			EXE_SRA:  alu_res = word_t'($signed(op1) >>> op2[SHAMT_W-1:0]);
			EXE_LUI:  alu_res = op1;
			default:  alu_res = sum;
		endcase
	end

	always_comb begin
		case (id_exe.op)
			EXE_BEQ:  taken = eq;
			EXE_BNE:  taken = !eq;
			EXE_BLT:  taken = lt || (id_exe.or_equal && eq);
			EXE_BLTU: taken = ltu || (id_exe.or_equal && eq);
			default:  taken = 1'b0;
		endcase
	end

	always_comb begin
		exe_mem_next.op = MEM_FORWARD;
		exe_mem_next.rd = id_exe.rd;
		exe_mem_next.target = op1 + offset_ext;
		exe_mem_next.result = alu_res;
		case (id_exe.op)
			EXE_JUMP: begin
				exe_mem_next.op = MEM_JUMP;
				exe_mem_next.target = {sum[`RV_XLEN-1:1], 1'b0};
				exe_mem_next.result = link;
			end
			EXE_BEQ, EXE_BNE, EXE_BLT, EXE_BLTU: begin
				// Not taken means nothing left to do
				exe_mem_next.op = taken ? MEM_JUMP : MEM_NOP;
				exe_mem_next.target = id_exe.pc + offset_ext;
				exe_mem_next.result = link;
			end
			EXE_LOAD: exe_mem_next.op = MEM_LOAD;
			EXE_STORE: begin
				exe_mem_next.op = MEM_STORE;
				exe_mem_next.result = op2;
			end
			EXE_NOP: exe_mem_next.op = MEM_NOP;
			default: exe_mem_next.op = MEM_FORWARD;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		exe_mem <= exe_mem_next;
		if (reset || redirect.valid) begin
			exe_mem.op <= MEM_NOP;
		end
	end

endmodule

// File: hdl/rv_memory.sv
`timescale 1ns/10ps

module rv_memory (
	input  logic               clk,
	input  logic               reset,
	input  rv_pkg::exe_mem_t   exe_mem,
	output rv_pkg::word_t      dmem_addr,
	output logic               dmem_we,
	output rv_pkg::word_t      dmem_wdata,
	input  rv_pkg::word_t      dmem_rdata,
	output rv_pkg::reg_write_t mem_fwd,
	output rv_pkg::reg_write_t wb_write,
	output rv_pkg::redirect_t  redirect
);
	import rv_pkg::*;

	mem_wb_t mem_wb;

	assign dmem_addr = exe_mem.target;
	assign dmem_wdata = exe_mem.result;
	// No store from the wrong path while WB redirects
	assign dmem_we = (exe_mem.op == MEM_STORE) && !redirect.valid;

	// Value this stage will write back, visible to execute
	always_comb begin
		mem_fwd.en = (exe_mem.op == MEM_FORWARD) || (exe_mem.op == MEM_LOAD);
		mem_fwd.rd = exe_mem.rd;
		mem_fwd.data = (exe_mem.op == MEM_LOAD) ? dmem_rdata : exe_mem.result;
	end

	// MEM/WB register
	always_ff @(posedge clk) begin
		mem_wb.rd <= exe_mem.rd;
		// For a jump this carries the link value
		mem_wb.result <= mem_fwd.data;
		mem_wb.target <= exe_mem.target;
		if (reset || redirect.valid) begin
			mem_wb.op <= WB_NOP;
		end else begin
			case (exe_mem.op)
				MEM_FORWARD, MEM_LOAD: mem_wb.op <= WB_WRITE;
				MEM_JUMP: mem_wb.op <= WB_JUMP;
				default: mem_wb.op <= WB_NOP;
			endcase
		end
	end

	// Jumps write the link and redirect in the same cycle
	always_comb begin
		wb_write.en = (mem_wb.op == WB_WRITE) || (mem_wb.op == WB_JUMP);
		wb_write.rd = mem_wb.rd;
		wb_write.data = mem_wb.result;
		redirect.valid = (mem_wb.op == WB_JUMP);
		redirect.target = mem_wb.target;
	end

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/10ps

module rv_core (
	input  logic          clk,
	input  logic          reset,
	output rv_pkg::word_t imem_addr,
	input  rv_pkg::word_t imem_data,
	output rv_pkg::word_t dmem_addr,
	output logic          dmem_we,
	output rv_pkg::word_t dmem_wdata,
	input  rv_pkg::word_t dmem_rdata
);
	import rv_pkg::*;

	logic       id_valid;
	word_t      id_inst;
	word_t      id_pc;
	reg_idx_t   rs1_idx;
	reg_idx_t   rs2_idx;
	word_t      rs1_val;
	word_t      rs2_val;
	id_exe_t    id_exe;
	exe_mem_t   exe_mem;
	reg_write_t mem_fwd;
	reg_write_t wb_write;
	redirect_t  redirect;

	rv_fetch u_fetch (
		.clk       (clk),
		.reset     (reset),
		.redirect  (redirect),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.id_valid  (id_valid),
		.id_inst   (id_inst),
		.id_pc     (id_pc)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.reset    (reset),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.wb_write (wb_write)
	);

	rv_decode u_decode (
		.clk      (clk),
		.reset    (reset),
		.id_valid (id_valid),
		.id_inst  (id_inst),
		.id_pc    (id_pc),
		.redirect (redirect),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.id_exe   (id_exe)
	);

	rv_execute u_execute (
		.clk      (clk),
		.reset    (reset),
		.id_exe   (id_exe),
		.redirect (redirect),
		.mem_fwd  (mem_fwd),
		.wb_write (wb_write),
		.exe_mem  (exe_mem)
	);

	rv_memory u_memory (
		.clk        (clk),
		.reset      (reset),
		.exe_mem    (exe_mem),
		.dmem_addr  (dmem_addr),
		.dmem_we    (dmem_we),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.mem_fwd    (mem_fwd),
		.wb_write   (wb_write),
		.redirect   (redirect)
	);

endmodule

// File: verification/rv_tb_clock.sv
`timescale 1ns/10ps

module rv_tb_clock (
	output logic clk
);

	// 4 ns period
	initial begin
		clk = 1'b0;
	end

	always begin
		#2 clk = ~clk;
	end

endmodule

// File: verification/rv_core_checker.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core_checker (
	input logic          clk,
	input logic          reset,
	input rv_pkg::word_t imem_addr,
	input logic          dmem_we
);

	store_strobe_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(dmem_we))
		else $error("dmem_we is unknown");

	no_store_after_reset: assert property (@(posedge clk) $fell(reset) |-> !dmem_we)
		else $error("dmem_we high in the first cycle after reset");

	fetch_aligned: assert property (@(posedge clk) disable iff (reset)
		imem_addr[1:0] == 2'b00)
		else $error("imem_addr not word aligned");

	// First fetch comes from the reset vector
	fetch_reset_pc: assert property (@(posedge clk) $fell(reset) |-> imem_addr == `RV_RESET_PC)
		else $error("imem_addr differs from the reset PC after reset");

endmodule

bind rv_core rv_core_checker u_checker (
	.clk       (clk),
	.reset     (reset),
	.imem_addr (imem_addr),
	.dmem_we   (dmem_we)
);

// File: verification/rv_tb.sv
`timescale 1ns/10ps

module rv_tb;
	import rv_pkg::*;

	localparam int IMEM_WORDS = 1024;
	localparam int DMEM_WORDS = 512;
	localparam int TIMEOUT = 5000;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam word_t NOP_WORD = 32'h0000_0013;
	localparam word_t SELF_JUMP = 32'h0000_006f;

	logic  clk;
	logic  reset;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	logic  dmem_we;
	word_t dmem_wdata;
	word_t dmem_rdata;
	word_t imem [IMEM_WORDS] = '{default: NOP_WORD};
	word_t dmem [DMEM_WORDS] = '{default: '0};
	word_t dmem_init [DMEM_WORDS] = '{default: '0};
	word_t prog [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	int    seen;

	rv_tb_clock u_clock (
		.clk (clk)
	);

	rv_core DUT (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_we    (dmem_we),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	// Both memories answer in the same cycle
	assign imem_data = imem[imem_addr[11:2]];
	assign dmem_rdata = dmem[dmem_addr[10:2]];

	function automatic word_t rtype(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t itype(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t stype(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t btype(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t utype(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t jtype(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Sequential ISA model that fills the expected store list
	function automatic void ref_run();
		word_t x [32];
		word_t dm [DMEM_WORDS];
		word_t pc;
		word_t npc;
		word_t inst;
		word_t a;
		word_t b;
		word_t res;
		word_t imm_i;
		word_t imm_s;
		word_t imm_b;
		word_t imm_j;
		word_t addr;
		logic [2:0] f3;
		logic [6:0] f7;
		logic wr;
		logic taken;
		exp_addr.delete();
		exp_data.delete();
		x = '{default: '0};
		dm = dmem_init;
		pc = '0;
		for (int step = 0; step < 4000; step++) begin
			inst = imem[pc[11:2]];
			if (inst == SELF_JUMP) begin
				break;
			end
			f3 = inst[14:12];
			f7 = inst[31:25];
			a = x[inst[19:15]];
			b = x[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			wr = 1'b0;
			res = '0;
			npc = pc + 32'd4;
			if (inst[1:0] == 2'b11) begin
				case (inst[6:2])
					5'b01100: begin
						if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
							res = alu_ref(f3, f7[5], a, b);
							wr = 1'b1;
						end
					end
					5'b00100: begin
						if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 ||
							(f3 == 3'd5 && f7 == 7'h20)) begin
							res = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
							wr = 1'b1;
						end
					end
					5'b01101: begin
						res = {inst[31:12], 12'b0};
						wr = 1'b1;
					end
					5'b00101: begin
						res = pc + {inst[31:12], 12'b0};
						wr = 1'b1;
					end
					5'b11011: begin
						res = pc + 32'd4;
						wr = 1'b1;
						npc = pc + imm_j;
					end
					5'b11001: begin
						if (f3 == 3'd0) begin
							res = pc + 32'd4;
							wr = 1'b1;
							npc = (a + imm_i) & ~32'd1;
						end
					end
					5'b11000: begin
						case (f3)
							3'd0: taken = a == b;
							3'd1: taken = a != b;
							3'd4: taken = $signed(a) < $signed(b);
							3'd5: taken = $signed(a) >= $signed(b);
							3'd6: taken = a < b;
							3'd7: taken = a >= b;
							default: taken = 1'b0;
						endcase
						if (taken) begin
							npc = pc + imm_b;
						end
					end
					5'b00000: begin
						if (f3 == 3'd2) begin
							addr = a + imm_i;
							res = dm[addr[10:2]];
							wr = 1'b1;
						end
					end
					5'b01000: begin
						if (f3 == 3'd2) begin
							addr = a + imm_s;
							dm[addr[10:2]] = b;
							exp_addr.push_back(addr);
							exp_data.push_back(b);
						end
					end
					default: wr = 1'b0;
				endcase
			end
			if (wr && inst[11:7] != 5'd0) begin
				x[inst[11:7]] = res;
			end
			pc = npc;
		end
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			fail_run("value compare failed");
		end
	endtask

	// Store comparator that also keeps the data memory
	always @(posedge clk) begin
		if (reset) begin
			seen <= 0;
			dmem <= dmem_init;
		end else if (dmem_we) begin
			if (seen >= exp_addr.size()) begin
				fail_run("store seen beyond the end of the expected store list");
			end else begin
				check_value("dmem_addr", dmem_addr, exp_addr[seen]);
				check_value("dmem_wdata", dmem_wdata, exp_data[seen]);
			end
			dmem[dmem_addr[10:2]] <= dmem_wdata;
			seen <= seen + 1;
		end
	end

	task automatic run_program();
		int cycles;
		@(posedge clk);
		reset <= 1'b1;
		// Load the next program while the core is in reset
		@(posedge clk);
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : NOP_WORD;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem_init[i] = $urandom;
		end
		ref_run();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (seen < exp_addr.size()) begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				fail_run("timeout while waiting for the expected stores");
			end
		end
		// Any further store is caught by the comparator
		repeat (32) @(posedge clk);
	endtask

	task automatic build_alu_program();
		logic [4:0] rd;
		logic [2:0] f3;
		logic [11:0] imm;
		int sel;
		prog.delete();
		for (int r = 1; r < 8; r++) begin
			prog.push_back(itype(12'($urandom), 5'd0, 3'd0, 5'(r), OPC_OP_IMM));
		end
		for (int i = 0; i < 40; i++) begin
			sel = $urandom_range(0, 9);
			rd = 5'($urandom_range(0, 7));
			f3 = 3'($urandom);
			imm = 12'($urandom);
			if (sel < 4) begin
				prog.push_back(rtype(((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ?
					7'h20 : 7'h00, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), f3, rd));
			end else if (sel < 7) begin
				if (f3 == 3'd1 || f3 == 3'd5) begin
					imm[11:5] = (f3 == 3'd5 && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
				end
				prog.push_back(itype(imm, 5'($urandom_range(0, 7)), f3, rd, OPC_OP_IMM));
			end else if (sel == 7) begin
				prog.push_back(utype(20'($urandom), rd, 7'b0110111));
			end else if (sel == 8) begin
				prog.push_back(utype(20'($urandom), rd, 7'b0010111));
			end else begin
				// SYSTEM or an illegal word
				prog.push_back(($urandom_range(0, 1) == 1) ? 32'h0000_0073 : 32'hffff_ffff);
			end
			prog.push_back(stype(12'(i * 4), rd, 5'd0));
		end
		prog.push_back(SELF_JUMP);
	endtask

	task automatic build_mem_program();
		prog.delete();
		prog.push_back(itype(12'h100, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
		for (int i = 0; i < 8; i++) begin
			prog.push_back(itype(12'($urandom), 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
			prog.push_back(stype(12'(i * 4), 5'd2, 5'd1));
			prog.push_back(itype(12'(i * 4), 5'd1, 3'd2, 5'd3, OPC_LOAD));
			// Load result used by the next instruction
			prog.push_back(rtype(7'h00, 5'd3, 5'd3, 3'd0, 5'd4));
			prog.push_back(stype(12'(32 + i * 4), 5'd4, 5'd1));
			prog.push_back(itype(12'(128 + i * 4), 5'd1, 3'd2, 5'd5, OPC_LOAD));
			prog.push_back(stype(12'(64 + i * 4), 5'd5, 5'd1));
		end
		prog.push_back(SELF_JUMP);
	endtask

	task automatic build_branch_program();
		logic [2:0] kinds [6];
		logic [4:0] lhs [3];
		logic [4:0] rhs [3];
		int slot;
		kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		lhs = '{5'd1, 5'd2, 5'd2};
		rhs = '{5'd2, 5'd1, 5'd3};
		slot = 0;
		prog.delete();
		// x1 negative and x2 positive, so signed and unsigned order differ
		prog.push_back(itype({1'b1, 11'($urandom)}, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
		prog.push_back(itype({1'b0, 11'($urandom)}, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
		prog.push_back(itype(12'd0, 5'd2, 3'd0, 5'd3, OPC_OP_IMM));
		prog.push_back(itype(12'd1, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
		prog.push_back(itype(12'd2, 5'd0, 3'd0, 5'd7, OPC_OP_IMM));
		for (int p = 0; p < 3; p++) begin
			for (int k = 0; k < 6; k++) begin
				// Taken skips the first marker store
				prog.push_back(btype(13'd8, rhs[p], lhs[p], kinds[k]));
				prog.push_back(stype(12'(slot * 4), 5'd7, 5'd0));
				prog.push_back(stype(12'(slot * 4 + 4), 5'd6, 5'd0));
				slot += 2;
			end
		end
		prog.push_back(jtype(21'd8, 5'd5));
		prog.push_back(stype(12'(slot * 4), 5'd7, 5'd0));
		prog.push_back(stype(12'(slot * 4 + 4), 5'd5, 5'd0));
		prog.push_back(utype(20'd0, 5'd8, 7'b0010111));
		prog.push_back(itype(12'd16, 5'd8, 3'd0, 5'd9, OPC_JALR));
		prog.push_back(stype(12'(slot * 4 + 8), 5'd7, 5'd0));
		prog.push_back(stype(12'(slot * 4 + 12), 5'd7, 5'd0));
		prog.push_back(stype(12'(slot * 4 + 16), 5'd9, 5'd0));
		prog.push_back(SELF_JUMP);
	endtask

	initial begin
		void'($urandom(32'ha439));
		reset = 1'b1;
		build_alu_program();
		run_program();
		build_mem_program();
		run_program();
		build_branch_program();
		run_program();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: riscv_core.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_core.sv
verification/rv_tb_clock.sv
verification/rv_core_checker.sv
verification/rv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; the pass line in the output decides the result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module rv_tb \
		-f riscv_core.f -o Vrv_tb \
	&& ./obj_dir/Vrv_tb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
